//--- pe_pkg.sv
package pe_pkg;

    localparam int INT_BITS   = 4;
    localparam int FRAC_BITS  = 16;
    localparam int DATA_W     = INT_BITS + FRAC_BITS;
    localparam int TILE_ROWS  = 4;
    localparam int TILE_COLS  = 4;
    localparam int TILE_ELEMS = TILE_ROWS * TILE_COLS;
    localparam int ELEM_IDX_W = $clog2(TILE_ELEMS);
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int ACC_W      = 48; // room for 16 full 40-bit products.

    // signed Q4.16 value.
    typedef logic signed [DATA_W-1:0] data_t;

    typedef logic signed [ACC_W-1:0] acc_t;

    // one bit per element, k = row*4 + col.
    typedef logic [TILE_ELEMS-1:0] mask_t;

    typedef logic [ELEM_IDX_W-1:0] elem_idx_t;

    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

    typedef data_t [TILE_ELEMS-1:0] tile_t;

    // one selected activation/weight pair on its way to the MAC.
    typedef struct packed {
        data_t act;
        data_t wgt;
        logic  last; // final pair of a tile.
    } pair_t;

endpackage

//--- tile_transposer.sv
`timescale 1ns/100ps

module tile_transposer (
    input  logic          clk,
    input  logic          i_reset,
    input  logic          i_load,
    input  logic          i_mode,
    input  pe_pkg::tile_t i_in,
    input  logic          i_taken,
    output logic          o_ready,
    output logic          o_valid,
    output pe_pkg::tile_t o_tile
);

    import pe_pkg::*;

    typedef enum logic {
        EMPTY,
        FULL
    } state_t;

    state_t state;
    tile_t  tile_q;
    tile_t  tile_t_in; // transposed view of i_in.

    always_comb begin
        for (int r = 0; r < TILE_ROWS; r++) begin
            for (int c = 0; c < TILE_COLS; c++) begin
                tile_t_in[r*TILE_COLS + c] = i_in[c*TILE_ROWS + r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= EMPTY;
        end else if (state == EMPTY && i_load) begin
            state <= FULL;
        end else if (state == FULL && i_taken) begin
            state <= EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            tile_q <= i_mode ? i_in : tile_t_in; // mode 1 passes through.
        end
    end

    assign o_ready = (state == EMPTY);
    assign o_valid = (state == FULL);
    assign o_tile  = tile_q;

    // the top level gates loads with o_ready.
    a_no_load_when_full: assert property (
        @(posedge clk) disable iff (i_reset) i_load |-> state == EMPTY);

endmodule

//--- sparsity_packer.sv
`timescale 1ns/100ps

module sparsity_packer (
    input  logic          clk,
    input  logic          i_reset,
    input  logic          i_valid,
    input  pe_pkg::tile_t i_tile,
    input  pe_pkg::tile_t i_w,
    input  pe_pkg::mask_t i_in_mask,
    input  pe_pkg::mask_t i_w_mask,
    input  logic          i_full,
    output logic          o_taken,
    output logic          o_push,
    output pe_pkg::pair_t o_pair
);

    import pe_pkg::*;

    typedef enum logic {
        IDLE,
        SEND
    } state_t;

    state_t    state;
    tile_t     act_q;
    tile_t     wgt_q;
    mask_t     remaining; // combined mask bits not yet sent.
    mask_t     rest;
    elem_idx_t sel_idx;

    // lowest set bit of the remaining mask.
    always_comb begin
        sel_idx = '0;
        for (int k = TILE_ELEMS - 1; k >= 0; k--) begin
            if (remaining[k]) begin
                sel_idx = elem_idx_t'(k);
            end
        end
    end

    assign rest    = remaining & (remaining - 1'b1); // drops the lowest set bit.
    assign o_taken = (state == IDLE) && i_valid;
    assign o_push  = (state == SEND) && !i_full;

    always_comb begin
        o_pair.act = '0;
        o_pair.wgt = '0;
        if (remaining != '0) begin
            o_pair.act = act_q[sel_idx];
            o_pair.wgt = wgt_q[sel_idx];
        end
        // an empty combined mask still sends one zero pair with last set.
        o_pair.last = (rest == '0);
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state     <= IDLE;
            remaining <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (o_taken) begin
                        state     <= SEND;
                        remaining <= i_in_mask & i_w_mask;
                    end
                end
                SEND: begin
                    if (o_push) begin
                        remaining <= rest;
                        if (o_pair.last) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_taken) begin
            act_q <= i_tile;
            wgt_q <= i_w;
        end
    end

    // the tile stage keeps its tile until the packer takes it.
    a_valid_held_until_taken: assert property (
        @(posedge clk) disable iff (i_reset)
        i_valid && !o_taken |=> i_valid && $stable(i_tile));

endmodule

//--- pair_fifo.sv
`timescale 1ns/100ps

module pair_fifo (
    input  logic          clk,
    input  logic          i_reset,
    input  logic          i_push,
    input  pe_pkg::pair_t i_pair,
    input  logic          i_pop,
    output pe_pkg::pair_t o_pair,
    output logic          o_empty,
    output logic          o_full
);

    import pe_pkg::*;

    pair_t     mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    logic      do_push;
    logic      do_pop;

    assign o_empty = (count == '0);
    assign o_full  = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    assign o_pair = mem[rd_ptr]; // head is visible before the pop.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_pair;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (i_reset) i_push |-> !o_full);

    a_no_underflow: assert property (
        @(posedge clk) disable iff (i_reset) i_pop |-> !o_empty);

endmodule

//--- mac_accumulator.sv
`timescale 1ns/100ps

module mac_accumulator (
    input  logic          clk,
    input  logic          i_reset,
    input  logic          i_empty,
    input  pe_pkg::pair_t i_pair,
    output logic          o_pop,
    output logic          o_result_valid,
    output pe_pkg::data_t o_result
);

    import pe_pkg::*;

    acc_t acc;
    acc_t product;
    acc_t sum;
    acc_t scaled;

    assign o_pop = !i_empty; // drain one pair per cycle.

    always_comb begin
        product = i_pair.act * i_pair.wgt; // full Q8.32 product, sign extended.
        sum     = acc + product;
        scaled  = sum >>> FRAC_BITS;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            acc            <= '0;
            o_result_valid <= 1'b0;
        end else begin
            o_result_valid <= 1'b0;
            if (o_pop) begin
                if (i_pair.last) begin
                    acc            <= '0;
                    o_result_valid <= 1'b1;
                end else begin
                    acc <= sum;
                end
            end
        end
    end

    // back to Q4.16, upper bits are dropped.
    always_ff @(posedge clk) begin
        if (o_pop && i_pair.last) begin
            o_result <= scaled[DATA_W-1:0];
        end
    end

endmodule

//--- pe.sv
`timescale 1ns/100ps

module pe (
    input  logic          clk,
    input  logic          i_reset,
    input  logic          i_input_ready,
    input  logic          i_mode,
    input  pe_pkg::tile_t i_in,
    input  pe_pkg::tile_t i_w,
    input  pe_pkg::mask_t i_in_mask,
    input  pe_pkg::mask_t i_w_mask,
    output logic          o_ready,
    output logic          o_result_valid,
    output pe_pkg::data_t o_result
);

    import pe_pkg::*;

    logic  accept;
    logic  tile_valid;
    logic  tile_taken;
    tile_t tile;
    tile_t w_q;
    mask_t in_mask_q;
    mask_t w_mask_q;
    logic  push;
    pair_t push_pair;
    logic  pop;
    pair_t pop_pair;
    logic  fifo_empty;
    logic  fifo_full;

    assign accept = i_input_ready && o_ready; // strobes while busy are dropped.

    // weights and masks sit beside the tile stage, never transposed.
    always_ff @(posedge clk) begin
        if (accept) begin
            w_q       <= i_w;
            in_mask_q <= i_in_mask;
            w_mask_q  <= i_w_mask;
        end
    end

    tile_transposer u_tile_transposer (
        .clk(clk), .i_reset(i_reset), .i_load(accept), .i_mode(i_mode), .i_in(i_in),
        .i_taken(tile_taken), .o_ready(o_ready), .o_valid(tile_valid), .o_tile(tile)
    );

    sparsity_packer u_sparsity_packer (
        .clk(clk), .i_reset(i_reset), .i_valid(tile_valid), .i_tile(tile), .i_w(w_q),
        .i_in_mask(in_mask_q), .i_w_mask(w_mask_q), .i_full(fifo_full),
        .o_taken(tile_taken), .o_push(push), .o_pair(push_pair)
    );

    pair_fifo u_pair_fifo (
        .clk(clk), .i_reset(i_reset), .i_push(push), .i_pair(push_pair), .i_pop(pop),
        .o_pair(pop_pair), .o_empty(fifo_empty), .o_full(fifo_full)
    );

    mac_accumulator u_mac_accumulator (
        .clk(clk), .i_reset(i_reset), .i_empty(fifo_empty), .i_pair(pop_pair),
        .o_pop(pop), .o_result_valid(o_result_valid), .o_result(o_result)
    );

endmodule

//--- tb_pe.sv
`timescale 1ns/100ps

module tb_pe;

    import pe_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 2;
    localparam int READY_TIMEOUT  = 100;
    localparam int RESULT_TIMEOUT = 200;
    localparam int DRAIN_CYCLES   = 40;
    localparam int WORDS_PER_TILE = 3 + 2*TILE_ELEMS + 1; // mode, masks, data, weights, result.
    localparam int MAX_TILES      = 32;
    localparam logic [DATA_W-1:0] END_MARK = '1;

    logic  clk;
    logic  i_reset;
    logic  i_input_ready;
    logic  i_mode;
    tile_t i_in;
    tile_t i_w;
    mask_t i_in_mask;
    mask_t i_w_mask;
    logic  o_ready;
    logic  o_result_valid;
    data_t o_result;

    logic [DATA_W-1:0] pattern_mem [WORDS_PER_TILE*MAX_TILES];
    data_t expected_q [$];
    int    num_tiles;
    int    sent_count;
    int    recv_count;
    int    error_count;
    int    test_count;
    int    failed_tests;
    bit    timed_out;

    pe u_pe (
        .clk(clk), .i_reset(i_reset), .i_input_ready(i_input_ready), .i_mode(i_mode),
        .i_in(i_in), .i_w(i_w), .i_in_mask(i_in_mask), .i_w_mask(i_w_mask),
        .o_ready(o_ready), .o_result_valid(o_result_valid), .o_result(o_result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic check_result(input data_t actual, input data_t expected);
        if (actual !== expected) begin
            $display("ERROR o_result: got %05h, expected %05h", actual, expected);
            error_count++;
        end
    endtask

    task automatic check_level(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            $display("ERROR %s: got %0h, expected %0h", name, actual, expected);
            error_count++;
        end
    endtask

    // results are matched in acceptance order.
    always @(negedge clk) begin
        if (!i_reset && o_result_valid === 1'b1) begin
            recv_count++;
            if (expected_q.size() == 0) begin
                $display("a result of %05h came out with no tile outstanding", o_result);
                error_count++;
            end else begin
                check_result(o_result, expected_q.pop_front());
            end
        end
    end

    task automatic load_patterns();
        for (int i = 0; i < WORDS_PER_TILE*MAX_TILES; i++) begin
            pattern_mem[i] = END_MARK;
        end
        $readmemh("pe_patterns.txt", pattern_mem);
        num_tiles = 0;
        while (num_tiles < MAX_TILES && pattern_mem[num_tiles*WORDS_PER_TILE] != END_MARK) begin
            num_tiles++;
        end
    endtask

    task automatic send_tile(input int idx, input bit stray);
        int base;
        int cycles;
        base   = idx * WORDS_PER_TILE;
        cycles = 0;
        while (o_ready !== 1'b1 && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (o_ready !== 1'b1) begin
            $display("timed out waiting for o_ready before tile %0d", idx);
            error_count++;
            timed_out = 1'b1;
        end else begin
            i_mode    = pattern_mem[base][0];
            i_in_mask = pattern_mem[base+1][TILE_ELEMS-1:0];
            i_w_mask  = pattern_mem[base+2][TILE_ELEMS-1:0];
            for (int k = 0; k < TILE_ELEMS; k++) begin
                i_in[k] = pattern_mem[base+3+k];
                i_w[k]  = pattern_mem[base+3+TILE_ELEMS+k];
            end
            i_input_ready = 1'b1;
            expected_q.push_back(pattern_mem[base+3+2*TILE_ELEMS]);
            sent_count++;
            @(negedge clk);
            check_level(o_ready, 1'b0, "o_ready"); // stage holds the tile now.
            if (stray) begin
                // a strobe while busy, with other data, must be dropped.
                i_in = ~i_in;
                i_w  = ~i_w;
                @(negedge clk);
            end
            i_input_ready = 1'b0;
        end
    endtask

    task automatic wait_results(input int target);
        int cycles;
        cycles = 0;
        while (recv_count < target && cycles < RESULT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (recv_count < target) begin
            $display("timed out waiting for o_result_valid, %0d of %0d results seen",
                     recv_count, target);
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d, %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d, %s: failed with %0d errors", test_count, name,
                     error_count - errors_before);
        end
    endtask

    task automatic finish_run();
        $display("tests %0d, failed %0d, errors %0d, results %0d of %0d", test_count,
                 failed_tests, error_count, recv_count, sent_count);
        if (error_count == 0 && failed_tests == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    initial begin
        int errors_before;
        i_reset       = 1'b1;
        i_input_ready = 1'b0;
        i_mode        = 1'b1;
        i_in          = '0;
        i_w           = '0;
        i_in_mask     = '0;
        i_w_mask      = '0;
        sent_count    = 0;
        recv_count    = 0;
        error_count   = 0;
        test_count    = 0;
        failed_tests  = 0;
        timed_out     = 1'b0;
        load_patterns();
        if (num_tiles == 0) begin
            $display("no tiles could be read from pe_patterns.txt");
            error_count++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;

        errors_before = error_count;
        check_level(o_ready, 1'b1, "o_ready");
        check_level(o_result_valid, 1'b0, "o_result_valid");
        report_test("levels after reset", errors_before);

        // one tile at a time through an empty pipeline.
        for (int t = 0; t < num_tiles && !timed_out; t++) begin
            errors_before = error_count;
            send_tile(t, t == 0);
            if (!timed_out) begin
                wait_results(sent_count);
            end
            report_test($sformatf("tile %0d alone, mode %0d", t, pattern_mem[t*WORDS_PER_TILE][0]),
                        errors_before);
        end

        if (!timed_out && num_tiles > 0) begin
            errors_before = error_count;
            for (int t = 0; t < num_tiles && !timed_out; t++) begin
                send_tile(t, 1'b0);
            end
            if (!timed_out) begin
                wait_results(sent_count);
            end
            repeat (DRAIN_CYCLES) @(negedge clk); // catch any extra result.
            if (recv_count != sent_count) begin
                $display("%0d results came out for %0d tiles sent", recv_count, sent_count);
                error_count++;
            end
            report_test("back-to-back tiles", errors_before);
        end
        finish_run();
    end

endmodule

//--- pe_patterns.txt
// mode in_mask w_mask, data k=0..15, weights k=0..15, expected result; all hex, Q4.16
// mode 1 passes the data tile through, mode 0 transposes it; k = row*4 + col
1 FFFF FFFF 10000 F0000 08000 20000 F8000 04000 18000 E0000 0C000 FC000 10000 08000 E8000 20000 F4000 02000 08000 10000 F0000 04000 20000 F0000 08000 08000 F0000 10000 04000 F8000 08000 04000 10000 20000 C4000
0 FFFF FFFF 10000 F0000 08000 20000 F8000 04000 18000 E0000 0C000 FC000 10000 08000 E8000 20000 F4000 02000 08000 10000 F0000 04000 20000 F0000 08000 08000 F0000 10000 04000 F8000 08000 04000 10000 20000 06000
1 A5F0 3CCC 10000 F0000 08000 20000 F8000 04000 18000 E0000 0C000 FC000 10000 08000 E8000 20000 F4000 02000 08000 10000 F0000 04000 20000 F0000 08000 08000 F0000 10000 04000 F8000 08000 04000 10000 20000 08000
1 F0F0 0F0F 10000 F0000 08000 20000 F8000 04000 18000 E0000 0C000 FC000 10000 08000 E8000 20000 F4000 02000 08000 10000 F0000 04000 20000 F0000 08000 08000 F0000 10000 04000 F8000 08000 04000 10000 20000 00000
0 0002 FFFF 10000 F0000 08000 20000 F8000 04000 18000 E0000 0C000 FC000 10000 08000 E8000 20000 F4000 02000 08000 10000 F0000 04000 20000 F0000 08000 08000 F0000 10000 04000 F8000 08000 04000 10000 20000 F8000
1 8001 FFFF FFFFF 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 00003 08000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 00002
0 0001 0001 FFFFF 20000 20000 20000 20000 20000 20000 20000 20000 20000 20000 20000 20000 20000 20000 20000 08000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 FFFFF
0 FFFF FFFF 30000 30000 30000 30000 30000 30000 30000 30000 30000 30000 30000 30000 30000 30000 30000 30000 18000 18000 18000 18000 18000 18000 18000 18000 18000 18000 18000 18000 18000 18000 18000 18000 80000

//--- pe.f
pe_pkg.sv
tile_transposer.sv
sparsity_packer.sv
pair_fifo.sv
mac_accumulator.sv
pe.sv
tb_pe.sv

//--- run_sim.sh
#!/bin/sh
# builds the pe lane testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_pe -f pe.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_pe > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$SIM_LOG"; then
    exit 1
fi
exit 0
